// ==== verilog/mrp_pkg.sv ====
`default_nettype none
package mrp_pkg;
    localparam int CONN_ID_W    = 3;
    localparam int MAX_CONNS    = 8;
    localparam int IP_ADDR_W    = 32;
    localparam int PORT_NUM_W   = 16;
    localparam int UDP_LENGTH_W = 16;
    localparam int DATA_W       = 64;
    localparam int PADBYTES_W   = 3;
    localparam int MSG_ID_W     = 16;
    localparam int PKT_IDX_W    = 16;
    localparam int PKT_BEATS_W  = 3;   // Holds up to four payload beats.
    localparam int PKT_CNT_W    = 64;

    // Key layout from the MSB: src ip, dst ip, src port, dst port.
    localparam int CONN_KEY_W = 2 * IP_ADDR_W + 2 * PORT_NUM_W;

    localparam logic [UDP_LENGTH_W-1:0] BEAT_BYTES        = 16'd8;
    localparam logic [UDP_LENGTH_W-1:0] MAX_PAYLOAD_BYTES = 16'd32;
    localparam logic [UDP_LENGTH_W-1:0] MRP_HDR_BYTES     = 16'd8;
    localparam logic [UDP_LENGTH_W-1:0] UDP_HDR_BYTES     = 16'd8;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        PKT_META,
        PKT_HDR,
        PKT_DATA,
        FINALIZE,
        WRITEBACK
    } tx_state_e;

    typedef enum logic {
        HDR,
        PAYLOAD
    } tx_data_sel_e;

    typedef enum logic {
        ZERO,
        INSTREAM
    } tx_pad_sel_e;
endpackage
`default_nettype wire

// ==== verilog/mrp_conn_table.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_conn_table (
     input  logic                               clk
    ,input  logic                               rst_n

    ,input  logic                               wr_val
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]    wr_conn_id
    ,input  logic   [mrp_pkg::CONN_KEY_W-1:0]   wr_key

    ,input  logic                               rd_val
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]    rd_conn_id
    ,output logic   [mrp_pkg::CONN_KEY_W-1:0]   rd_data

    ,output logic                               new_flow_val
    ,output logic   [mrp_pkg::CONN_ID_W-1:0]    new_flow_conn_id
);
    logic [mrp_pkg::CONN_KEY_W-1:0] keys [mrp_pkg::MAX_CONNS];

    // All connections closed out of reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            keys <= '{default: '0};
        end else if (wr_val) begin
            keys[wr_conn_id] <= wr_key;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_val) begin
            rd_data <= keys[rd_conn_id];   // One cycle read.
        end
    end

    // Any table write opens a fresh flow.
    assign new_flow_val     = wr_val;
    assign new_flow_conn_id = wr_conn_id;
endmodule
`default_nettype wire

// ==== verilog/mrp_tx_state_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_tx_state_mem (
     input  logic                               clk
    ,input  logic                               rst_n

    ,input  logic                               new_flow_val
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]    new_flow_conn_id

    ,input  logic                               wr_val
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]    wr_conn_id
    ,input  logic   [mrp_pkg::MSG_ID_W-1:0]     wr_msg_id
    ,output logic                               wr_rdy

    ,input  logic                               rd_val
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]    rd_conn_id
    ,output logic   [mrp_pkg::MSG_ID_W-1:0]     rd_msg_id
);
    logic [mrp_pkg::MSG_ID_W-1:0] msg_ids [mrp_pkg::MAX_CONNS];

    assign wr_rdy = ~new_flow_val;   // New flow owns the write port.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msg_ids <= '{default: '0};
        end else if (new_flow_val) begin
            msg_ids[new_flow_conn_id] <= '0;
        end else if (wr_val) begin
            msg_ids[wr_conn_id] <= wr_msg_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_val) begin
            rd_msg_id <= msg_ids[rd_conn_id];
        end
    end
endmodule
`default_nettype wire

// ==== verilog/mrp_tx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_tx_ctrl (
     input  logic                               clk
    ,input  logic                               rst_n

    ,input  logic                               src_tx_meta_val
    ,output logic                               tx_meta_rdy

    ,input  logic                               src_tx_instream_val
    ,input  logic                               src_tx_instream_last
    ,output logic                               tx_instream_rdy

    ,output logic                               dst_tx_meta_val
    ,input  logic                               dst_tx_meta_rdy

    ,output logic                               dst_tx_data_val
    ,output logic                               dst_tx_data_last
    ,input  logic                               dst_tx_data_rdy

    ,output logic                               finalize_val
    ,input  logic                               finalize_rdy

    ,output logic                               table_rd_val
    ,output logic                               state_rd_val
    ,output logic                               state_wr_val
    ,input  logic                               state_wr_rdy

    ,output logic                               store_meta
    ,output logic                               store_lookup
    ,output logic                               start_pkt
    ,output logic                               incr_msg_id
    ,output logic                               decr_bytes
    ,output mrp_pkg::tx_data_sel_e              data_sel
    ,output mrp_pkg::tx_pad_sel_e               pad_sel

    ,input  logic                               pkt_last_beat
    ,input  logic                               msg_last_pkt

    ,output logic   [mrp_pkg::PKT_CNT_W-1:0]    pkts_sent_cnt
);
    mrp_pkg::tx_state_e state;
    mrp_pkg::tx_state_e state_next;
    logic               lookup_wait;   // Second LOOKUP cycle, responses valid.
    logic               pkt_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= mrp_pkg::IDLE;
            tx_meta_rdy   <= 1'b0;
            lookup_wait   <= 1'b0;
            pkts_sent_cnt <= '0;
        end else begin
            state       <= state_next;
            tx_meta_rdy <= (state_next == mrp_pkg::IDLE);
            lookup_wait <= (state == mrp_pkg::LOOKUP) & ~lookup_wait;
            if (pkt_done) begin
                pkts_sent_cnt <= pkts_sent_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next       = state;
        tx_instream_rdy  = 1'b0;
        dst_tx_meta_val  = 1'b0;
        dst_tx_data_val  = 1'b0;
        dst_tx_data_last = 1'b0;
        finalize_val     = 1'b0;
        table_rd_val     = 1'b0;
        state_rd_val     = 1'b0;
        state_wr_val     = 1'b0;
        store_meta       = 1'b0;
        store_lookup     = 1'b0;
        start_pkt        = 1'b0;
        incr_msg_id      = 1'b0;
        decr_bytes       = 1'b0;
        pkt_done         = 1'b0;
        data_sel         = mrp_pkg::PAYLOAD;
        pad_sel          = mrp_pkg::ZERO;

        case (state)
            mrp_pkg::IDLE: begin
                if (src_tx_meta_val && tx_meta_rdy) begin
                    store_meta = 1'b1;
                    state_next = mrp_pkg::LOOKUP;
                end
            end
            mrp_pkg::LOOKUP: begin
                if (!lookup_wait) begin
                    table_rd_val = 1'b1;
                    state_rd_val = 1'b1;
                end else begin
                    store_lookup = 1'b1;
                    state_next   = mrp_pkg::PKT_META;
                end
            end
            mrp_pkg::PKT_META: begin
                dst_tx_meta_val = 1'b1;
                if (dst_tx_meta_rdy) begin
                    start_pkt  = 1'b1;
                    state_next = mrp_pkg::PKT_HDR;
                end
            end
            mrp_pkg::PKT_HDR: begin
                dst_tx_data_val = 1'b1;
                data_sel        = mrp_pkg::HDR;
                if (dst_tx_data_rdy) begin
                    state_next = mrp_pkg::PKT_DATA;
                end
            end
            mrp_pkg::PKT_DATA: begin
                dst_tx_data_val  = src_tx_instream_val;
                tx_instream_rdy  = dst_tx_data_rdy;
                dst_tx_data_last = pkt_last_beat;
                if (src_tx_instream_last) begin
                    pad_sel = mrp_pkg::INSTREAM;   // Only the message tail is padded.
                end
                if (src_tx_instream_val && dst_tx_data_rdy) begin
                    decr_bytes = 1'b1;
                    if (pkt_last_beat) begin
                        pkt_done = 1'b1;
                        if (msg_last_pkt) begin
                            state_next = mrp_pkg::FINALIZE;
                        end else begin
                            state_next = mrp_pkg::PKT_META;
                        end
                    end
                end
            end
            mrp_pkg::FINALIZE: begin
                finalize_val = 1'b1;
                if (finalize_rdy) begin
                    incr_msg_id = 1'b1;
                    state_next  = mrp_pkg::WRITEBACK;
                end
            end
            mrp_pkg::WRITEBACK: begin
                state_wr_val = 1'b1;
                if (state_wr_rdy) begin
                    state_next = mrp_pkg::IDLE;
                end
            end
            default: begin
                state_next = mrp_pkg::IDLE;
            end
        endcase
    end
endmodule
`default_nettype wire

// ==== verilog/mrp_tx_datap.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_tx_datap (
     input  logic                                   clk
    ,input  logic                                   rst_n

    ,input  logic   [mrp_pkg::UDP_LENGTH_W-1:0]     src_tx_req_len
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]        src_tx_conn_id
    ,input  logic   [mrp_pkg::DATA_W-1:0]           src_tx_instream_data
    ,input  logic   [mrp_pkg::PADBYTES_W-1:0]       src_tx_instream_padbytes

    ,input  logic                                   store_meta
    ,input  logic                                   store_lookup
    ,input  logic                                   start_pkt
    ,input  logic                                   incr_msg_id
    ,input  logic                                   decr_bytes
    ,input  mrp_pkg::tx_data_sel_e                  data_sel
    ,input  mrp_pkg::tx_pad_sel_e                   pad_sel

    ,output logic                                   pkt_last_beat
    ,output logic                                   msg_last_pkt

    ,output logic   [mrp_pkg::CONN_ID_W-1:0]        rd_conn_id
    ,input  logic   [mrp_pkg::CONN_KEY_W-1:0]       table_rd_data
    ,input  logic   [mrp_pkg::MSG_ID_W-1:0]         state_rd_msg_id
    ,output logic   [mrp_pkg::MSG_ID_W-1:0]         wr_msg_id

    ,output logic   [mrp_pkg::IP_ADDR_W-1:0]        dst_tx_src_ip
    ,output logic   [mrp_pkg::IP_ADDR_W-1:0]        dst_tx_dst_ip
    ,output logic   [mrp_pkg::PORT_NUM_W-1:0]       dst_tx_src_port
    ,output logic   [mrp_pkg::PORT_NUM_W-1:0]       dst_tx_dst_port
    ,output logic   [mrp_pkg::UDP_LENGTH_W-1:0]     dst_tx_len
    ,output logic   [mrp_pkg::DATA_W-1:0]           dst_tx_data
    ,output logic   [mrp_pkg::PADBYTES_W-1:0]       dst_tx_data_padbytes

    ,output logic   [mrp_pkg::CONN_KEY_W-1:0]       finalize_key
    ,output logic   [mrp_pkg::CONN_ID_W-1:0]        finalize_conn_id
    ,output logic   [mrp_pkg::MSG_ID_W-1:0]         finalize_msg_id
);
    localparam int HDR_PAD_W = mrp_pkg::DATA_W - mrp_pkg::MSG_ID_W
                             - mrp_pkg::PKT_IDX_W - mrp_pkg::UDP_LENGTH_W;

    logic [mrp_pkg::UDP_LENGTH_W-1:0]   req_len_q;
    logic [mrp_pkg::UDP_LENGTH_W-1:0]   bytes_rem;   // Bytes not yet packetized.
    logic [mrp_pkg::UDP_LENGTH_W-1:0]   pkt_bytes;
    logic [mrp_pkg::UDP_LENGTH_W-1:0]   pkt_beats;
    logic [mrp_pkg::CONN_ID_W-1:0]      conn_id_q;
    logic [mrp_pkg::CONN_KEY_W-1:0]     key_q;
    logic [mrp_pkg::MSG_ID_W-1:0]       msg_id_q;
    logic [mrp_pkg::PKT_IDX_W-1:0]      pkt_idx;
    logic [mrp_pkg::PKT_BEATS_W-1:0]    beats_left;
    logic [mrp_pkg::DATA_W-1:0]         hdr;

    // bytes_rem only moves at packet end, so these hold for the whole packet.
    assign pkt_bytes    = (bytes_rem > mrp_pkg::MAX_PAYLOAD_BYTES) ?
                          mrp_pkg::MAX_PAYLOAD_BYTES : bytes_rem;
    assign pkt_beats    = (pkt_bytes + mrp_pkg::BEAT_BYTES - 1'b1) / mrp_pkg::BEAT_BYTES;
    assign msg_last_pkt = (bytes_rem <= mrp_pkg::MAX_PAYLOAD_BYTES);
    assign pkt_last_beat = (beats_left == 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bytes_rem  <= '0;
            pkt_idx    <= '0;
            beats_left <= '0;
        end else begin
            if (store_meta) begin
                bytes_rem <= src_tx_req_len;
                pkt_idx   <= '0;
            end else if (decr_bytes && pkt_last_beat) begin
                bytes_rem <= bytes_rem - pkt_bytes;
                pkt_idx   <= pkt_idx + 1'b1;
            end
            if (start_pkt) begin
                beats_left <= pkt_beats[mrp_pkg::PKT_BEATS_W-1:0];
            end else if (decr_bytes) begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_meta) begin
            req_len_q <= src_tx_req_len;
            conn_id_q <= src_tx_conn_id;
        end
        if (store_lookup) begin
            key_q <= table_rd_data;
        end
        if (store_lookup) begin
            msg_id_q <= state_rd_msg_id;
        end else if (incr_msg_id) begin
            msg_id_q <= msg_id_q + 1'b1;   // Next id, written back after finalize.
        end
    end

    assign rd_conn_id = conn_id_q;
    assign wr_msg_id  = msg_id_q;

    assign {dst_tx_src_ip, dst_tx_dst_ip, dst_tx_src_port, dst_tx_dst_port} = key_q;
    assign dst_tx_len = pkt_bytes + mrp_pkg::MRP_HDR_BYTES + mrp_pkg::UDP_HDR_BYTES;

    assign hdr = {msg_id_q, pkt_idx, req_len_q, {HDR_PAD_W{1'b0}}};
    assign dst_tx_data = (data_sel == mrp_pkg::HDR) ? hdr : src_tx_instream_data;
    assign dst_tx_data_padbytes = (pad_sel == mrp_pkg::INSTREAM) ?
                                  src_tx_instream_padbytes : '0;

    assign finalize_key     = key_q;
    assign finalize_conn_id = conn_id_q;
    assign finalize_msg_id  = msg_id_q;
endmodule
`default_nettype wire

// ==== verilog/mrp_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_tx (
     input  logic                                   clk
    ,input  logic                                   rst_n

    ,input  logic                                   table_wr_val
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]        table_wr_conn_id
    ,input  logic   [mrp_pkg::CONN_KEY_W-1:0]       table_wr_key

    ,input  logic                                   src_tx_meta_val
    ,input  logic   [mrp_pkg::UDP_LENGTH_W-1:0]     src_tx_req_len
    ,input  logic   [mrp_pkg::CONN_ID_W-1:0]        src_tx_conn_id
    ,output logic                                   tx_meta_rdy

    ,input  logic                                   src_tx_instream_val
    ,input  logic   [mrp_pkg::DATA_W-1:0]           src_tx_instream_data
    ,input  logic                                   src_tx_instream_last
    ,input  logic   [mrp_pkg::PADBYTES_W-1:0]       src_tx_instream_padbytes
    ,output logic                                   tx_instream_rdy

    ,output logic                                   dst_tx_meta_val
    ,output logic   [mrp_pkg::IP_ADDR_W-1:0]        dst_tx_src_ip
    ,output logic   [mrp_pkg::IP_ADDR_W-1:0]        dst_tx_dst_ip
    ,output logic   [mrp_pkg::PORT_NUM_W-1:0]       dst_tx_src_port
    ,output logic   [mrp_pkg::PORT_NUM_W-1:0]       dst_tx_dst_port
    ,output logic   [mrp_pkg::UDP_LENGTH_W-1:0]     dst_tx_len
    ,input  logic                                   dst_tx_meta_rdy

    ,output logic                                   dst_tx_data_val
    ,output logic   [mrp_pkg::DATA_W-1:0]           dst_tx_data
    ,output logic                                   dst_tx_data_last
    ,output logic   [mrp_pkg::PADBYTES_W-1:0]       dst_tx_data_padbytes
    ,input  logic                                   dst_tx_data_rdy

    ,output logic                                   finalize_val
    ,output logic   [mrp_pkg::CONN_KEY_W-1:0]       finalize_key
    ,output logic   [mrp_pkg::CONN_ID_W-1:0]        finalize_conn_id
    ,output logic   [mrp_pkg::MSG_ID_W-1:0]         finalize_msg_id
    ,input  logic                                   finalize_rdy

    ,output logic   [mrp_pkg::PKT_CNT_W-1:0]        pkts_sent_cnt
);
    logic                               store_meta;
    logic                               store_lookup;
    logic                               start_pkt;
    logic                               incr_msg_id;
    logic                               decr_bytes;
    mrp_pkg::tx_data_sel_e              data_sel;
    mrp_pkg::tx_pad_sel_e               pad_sel;
    logic                               pkt_last_beat;
    logic                               msg_last_pkt;

    logic                               table_rd_val;
    logic                               state_rd_val;
    logic                               state_wr_val;
    logic                               state_wr_rdy;
    logic [mrp_pkg::CONN_ID_W-1:0]      rd_conn_id;
    logic [mrp_pkg::CONN_KEY_W-1:0]     table_rd_data;
    logic [mrp_pkg::MSG_ID_W-1:0]       state_rd_msg_id;
    logic [mrp_pkg::MSG_ID_W-1:0]       wr_msg_id;

    logic                               new_flow_val;
    logic [mrp_pkg::CONN_ID_W-1:0]      new_flow_conn_id;

    mrp_conn_table conn_table (
         .clk               (clk                )
        ,.rst_n             (rst_n              )
        ,.wr_val            (table_wr_val       )
        ,.wr_conn_id        (table_wr_conn_id   )
        ,.wr_key            (table_wr_key       )
        ,.rd_val            (table_rd_val       )
        ,.rd_conn_id        (rd_conn_id         )
        ,.rd_data           (table_rd_data      )
        ,.new_flow_val      (new_flow_val       )
        ,.new_flow_conn_id  (new_flow_conn_id   )
    );

    mrp_tx_state_mem tx_state_mem (
         .clk               (clk                )
        ,.rst_n             (rst_n              )
        ,.new_flow_val      (new_flow_val       )
        ,.new_flow_conn_id  (new_flow_conn_id   )
        ,.wr_val            (state_wr_val       )
        ,.wr_conn_id        (rd_conn_id         )
        ,.wr_msg_id         (wr_msg_id          )
        ,.wr_rdy            (state_wr_rdy       )
        ,.rd_val            (state_rd_val       )
        ,.rd_conn_id        (rd_conn_id         )
        ,.rd_msg_id         (state_rd_msg_id    )
    );

    // Port names match the local nets one to one.
    mrp_tx_ctrl ctrl (.*);

    mrp_tx_datap datap (.*);
endmodule
`default_nettype wire

// ==== verif/mrp_tx_props.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_tx_props (
     input  logic                                   clk
    ,input  logic                                   rst_n
    ,input  logic                                   dst_tx_meta_val
    ,input  logic                                   dst_tx_meta_rdy
    ,input  logic   [mrp_pkg::UDP_LENGTH_W-1:0]     dst_tx_len
    ,input  logic                                   dst_tx_data_val
    ,input  logic                                   dst_tx_data_rdy
    ,input  logic   [mrp_pkg::DATA_W-1:0]           dst_tx_data
    ,input  logic                                   dst_tx_data_last
    ,input  mrp_pkg::tx_data_sel_e                  data_sel
    ,input  logic                                   finalize_val
    ,input  logic                                   finalize_rdy
);
    int unsigned fail_cnt;   // Failed checks so far.

    initial fail_cnt = 0;

    meta_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dst_tx_meta_val && !dst_tx_meta_rdy |=> dst_tx_meta_val && $stable(dst_tx_len))
    else begin
        $error("packet metadata dropped or changed while stalled");
        fail_cnt++;
    end

    // Header and payload beats both stay put under back-pressure.
    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dst_tx_data_val && !dst_tx_data_rdy |=>
            dst_tx_data_val && $stable(dst_tx_data) && $stable(dst_tx_data_last))
    else begin
        $error("data beat dropped or changed while stalled");
        fail_cnt++;
    end

    fin_hold: assert property (@(posedge clk) disable iff (!rst_n)
        finalize_val && !finalize_rdy |=> finalize_val)
    else begin
        $error("finalize dropped while stalled");
        fail_cnt++;
    end

    hdr_after_meta: assert property (@(posedge clk) disable iff (!rst_n)
        dst_tx_meta_val && dst_tx_meta_rdy |=> dst_tx_data_val && data_sel == mrp_pkg::HDR)
    else begin
        $error("no header beat after the metadata handshake");
        fail_cnt++;
    end

    fin_alone: assert property (@(posedge clk) disable iff (!rst_n)
        !(finalize_val && dst_tx_data_val))
    else begin
        $error("finalize raised while data is valid");
        fail_cnt++;
    end
endmodule

bind mrp_tx mrp_tx_props props_i (.*);
`default_nettype wire

// ==== verif/mrp_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
module mrp_tx_tb;
    logic clk, rst_n, table_wr_val, src_tx_meta_val, tx_meta_rdy;
    logic src_tx_instream_val, src_tx_instream_last, tx_instream_rdy;
    logic dst_tx_meta_val, dst_tx_meta_rdy, dst_tx_data_val, dst_tx_data_last, dst_tx_data_rdy;
    logic finalize_val, finalize_rdy;
    logic [mrp_pkg::CONN_ID_W-1:0]      table_wr_conn_id, src_tx_conn_id, finalize_conn_id;
    logic [mrp_pkg::CONN_KEY_W-1:0]     table_wr_key, finalize_key;
    logic [mrp_pkg::UDP_LENGTH_W-1:0]   src_tx_req_len, dst_tx_len;
    logic [mrp_pkg::DATA_W-1:0]         src_tx_instream_data, dst_tx_data;
    logic [mrp_pkg::PADBYTES_W-1:0]     src_tx_instream_padbytes, dst_tx_data_padbytes;
    logic [mrp_pkg::IP_ADDR_W-1:0]      dst_tx_src_ip, dst_tx_dst_ip;
    logic [mrp_pkg::PORT_NUM_W-1:0]     dst_tx_src_port, dst_tx_dst_port;
    logic [mrp_pkg::MSG_ID_W-1:0]       finalize_msg_id;
    logic [mrp_pkg::PKT_CNT_W-1:0]      pkts_sent_cnt;

    // Reference model of the table and the per-connection message id.
    logic [mrp_pkg::CONN_KEY_W-1:0]     key_model [mrp_pkg::MAX_CONNS];
    logic [mrp_pkg::MSG_ID_W-1:0]       id_model [mrp_pkg::MAX_CONNS];
    logic [111:0]                       exp_meta [$];   // Key, udp length.
    logic [67:0]                        exp_beat [$];   // Data, last, padbytes.
    logic [114:0]                       exp_fin [$];    // Key, conn id, msg id.
    logic [31:0]                        lfsr;
    logic                               bp_en;
    int pkts_exp, fins_exp, fins_seen, total_beats, cycles, msg_seq;

    mrp_tx dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // Taps 32, 22, 2, 1.
        return lfsr[0];
    endfunction

    function automatic logic [mrp_pkg::DATA_W-1:0] beat_data(input int seq, input int b);
        return {16'hbe00 + seq[15:0], b[15:0], 32'h1357_9bdf ^ {seq[15:0], b[15:0]}};
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_meta(
        input logic [mrp_pkg::IP_ADDR_W-1:0]    src_ip,
        input logic [mrp_pkg::IP_ADDR_W-1:0]    dst_ip,
        input logic [mrp_pkg::PORT_NUM_W-1:0]   src_port,
        input logic [mrp_pkg::PORT_NUM_W-1:0]   dst_port,
        input logic [mrp_pkg::UDP_LENGTH_W-1:0] len
    );
        logic [111:0] exp;
        if (exp_meta.size() == 0) begin
            stop_with_error("packet metadata was sent when none was expected");
        end else begin
            exp = exp_meta.pop_front();
            compare_value("dst_tx_src_ip", src_ip, exp[111:80]);
            compare_value("dst_tx_dst_ip", dst_ip, exp[79:48]);
            compare_value("dst_tx_src_port", src_port, exp[47:32]);
            compare_value("dst_tx_dst_port", dst_port, exp[31:16]);
            compare_value("dst_tx_len", len, exp[15:0]);
        end
    endtask

    task automatic check_beat(input logic [mrp_pkg::DATA_W-1:0] data, input logic last,
                              input logic [mrp_pkg::PADBYTES_W-1:0] pad);
        logic [67:0] exp;
        if (exp_beat.size() == 0) begin
            stop_with_error("a data beat was sent when none was expected");
        end else begin
            exp = exp_beat.pop_front();
            compare_value("dst_tx_data", data, exp[67:4]);
            compare_value("dst_tx_data_last", last, exp[3]);
            compare_value("dst_tx_data_padbytes", pad, exp[2:0]);
        end
    endtask

    task automatic check_finalize(input logic [mrp_pkg::CONN_KEY_W-1:0] key,
                                  input logic [mrp_pkg::CONN_ID_W-1:0] conn,
                                  input logic [mrp_pkg::MSG_ID_W-1:0] id);
        logic [114:0] exp;
        if (exp_fin.size() == 0) begin
            stop_with_error("a finalize record was sent when none was expected");
        end else begin
            exp = exp_fin.pop_front();
            compare_value("finalize_key", key, exp[114:19]);
            compare_value("finalize_conn_id", conn, exp[18:16]);
            compare_value("finalize_msg_id", id, exp[15:0]);
            fins_seen++;
        end
    endtask

    task automatic check_count(input logic [mrp_pkg::PKT_CNT_W-1:0] count);
        compare_value("pkts_sent_cnt", count, pkts_exp);
    endtask

    // Sink side ready takes one LFSR bit per signal.
    always @(posedge clk) begin
        logic bp;
        bp = bp_en;   // Mode as set before this edge.
        #0.5;
        dst_tx_meta_rdy = bp ? rand_bit() : 1'b1;
        dst_tx_data_rdy = bp ? rand_bit() : 1'b1;
        finalize_rdy    = bp ? rand_bit() : 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles > 200 + 20 * total_beats) begin
                stop_with_error($sformatf("timeout, no progress after %0d cycles", cycles));
            end
            if (dut_i.props_i.fail_cnt != 0) begin
                stop_with_error("a protocol assertion on the DUT outputs failed");
            end
            if (dst_tx_meta_val && dst_tx_meta_rdy) begin
                check_meta(dst_tx_src_ip, dst_tx_dst_ip, dst_tx_src_port, dst_tx_dst_port,
                           dst_tx_len);
            end
            if (dst_tx_data_val && dst_tx_data_rdy) begin
                check_beat(dst_tx_data, dst_tx_data_last, dst_tx_data_padbytes);
            end
            if (finalize_val && finalize_rdy) begin
                check_finalize(finalize_key, finalize_conn_id, finalize_msg_id);
            end
        end
    end

    // Packet payload is min(remaining, 32) and the udp length adds 16.
    task automatic expect_msg(input logic [mrp_pkg::CONN_ID_W-1:0] conn, input int len);
        int rem;
        int pay;
        int pkt_beats;
        int nbeats;
        int b;
        logic [15:0] idx;
        rem    = len;
        nbeats = (len + 7) / 8;
        b      = 0;
        idx    = '0;
        while (rem > 0) begin
            pay       = (rem > 32) ? 32 : rem;
            pkt_beats = (pay + 7) / 8;
            exp_meta.push_back({key_model[conn], 16'(pay + 16)});
            exp_beat.push_back({id_model[conn], idx, 16'(len), 16'h0, 1'b0, 3'h0});
            for (int k = 0; k < pkt_beats; k++) begin
                exp_beat.push_back({beat_data(msg_seq, b), k == pkt_beats - 1,
                                    (b == nbeats - 1) ? 3'(nbeats * 8 - len) : 3'h0});
                b++;
            end
            total_beats += 2 + pkt_beats;
            rem -= pay;
            idx++;
            pkts_exp++;
        end
        exp_fin.push_back({key_model[conn], conn, id_model[conn]});
        id_model[conn] = id_model[conn] + 1'b1;
        fins_exp++;
    endtask

    // Back at IDLE once every finalize is seen and the FSM takes metadata again.
    task automatic wait_idle();
        while (fins_seen != fins_exp || !tx_meta_rdy) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic send_msg(input logic [mrp_pkg::CONN_ID_W-1:0] conn, input int len);
        int   nbeats;
        logic acc;
        nbeats = (len + 7) / 8;
        expect_msg(conn, len);
        src_tx_meta_val = 1'b1;
        src_tx_req_len  = 16'(len);
        src_tx_conn_id  = conn;
        do begin
            @(posedge clk);
            acc = tx_meta_rdy;
            #0.5;
        end while (!acc);
        src_tx_meta_val = 1'b0;
        for (int b = 0; b < nbeats; b++) begin
            src_tx_instream_val  = 1'b1;
            src_tx_instream_data = beat_data(msg_seq, b);
            src_tx_instream_last = (b == nbeats - 1);
            // Inner beats carry junk padbytes that the DUT must zero.
            src_tx_instream_padbytes = (b == nbeats - 1) ? 3'(nbeats * 8 - len) : 3'h5;
            do begin
                @(posedge clk);
                acc = tx_instream_rdy;
                #0.5;
            end while (!acc);
        end
        src_tx_instream_val  = 1'b0;
        src_tx_instream_last = 1'b0;
        msg_seq++;
        wait_idle();
    endtask

    task automatic write_table(input logic [mrp_pkg::CONN_ID_W-1:0] conn,
                               input logic [31:0] dst_ip);
        table_wr_val     = 1'b1;
        table_wr_conn_id = conn;
        table_wr_key     = {32'h0a00_0001, dst_ip, 16'd4000 + 16'(conn), 16'd7000};
        @(posedge clk);
        #0.5;
        table_wr_val    = 1'b0;
        key_model[conn] = table_wr_key;
        id_model[conn]  = '0;   // A write opens a fresh flow.
    endtask

    task automatic short_message();
        write_table(3'd1, 32'hc0a8_0001);
        send_msg(3'd1, 5);
        send_msg(3'd1, 8);
    endtask

    task automatic hundred_byte_message();
        write_table(3'd2, 32'hc0a8_0002);
        send_msg(3'd2, 100);   // 32, 32, 32 and 4 bytes.
    endtask

    task automatic msg_id_sequence();
        write_table(3'd4, 32'hc0a8_0004);
        send_msg(3'd4, 40);
        send_msg(3'd4, 17);
    endtask

    task automatic table_rewrite();
        write_table(3'd5, 32'hc0a8_0005);
        send_msg(3'd5, 64);
        send_msg(3'd2, 24);
        write_table(3'd2, 32'hc0a8_0202);
        send_msg(3'd2, 24);
        send_msg(3'd5, 9);
    endtask

    task automatic random_back_pressure();
        bp_en = 1'b1;
        send_msg(3'd1, 70);
        send_msg(3'd4, 8);
        send_msg(3'd5, 33);
        send_msg(3'd2, 129);
        bp_en = 1'b0;
    endtask

    task automatic packet_count();
        check_count(pkts_sent_cnt);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        {table_wr_val, src_tx_meta_val, src_tx_instream_val, src_tx_instream_last} = '0;
        {table_wr_conn_id, table_wr_key, src_tx_req_len, src_tx_conn_id} = '0;
        {src_tx_instream_data, src_tx_instream_padbytes} = '0;
        {dst_tx_meta_rdy, dst_tx_data_rdy, finalize_rdy} = '0;
        lfsr      = 32'h4660;
        bp_en     = 1'b0;
        key_model = '{default: '0};
        id_model  = '{default: '0};
        {pkts_exp, fins_exp, fins_seen, total_beats, cycles, msg_seq} = '0;
        repeat (16) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        short_message();
        hundred_byte_message();
        msg_id_sequence();
        table_rewrite();
        random_back_pressure();
        packet_count();
        if (exp_meta.size() == 0 && exp_beat.size() == 0 && exp_fin.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_error("expected packet records were never produced by the DUT");
        end
    end
endmodule
`default_nettype wire

// ==== verilog.f ====
verilog/mrp_pkg.sv
verilog/mrp_conn_table.sv
verilog/mrp_tx_state_mem.sv
verilog/mrp_tx_ctrl.sv
verilog/mrp_tx_datap.sv
verilog/mrp_tx.sv
verif/mrp_tx_props.sv
verif/mrp_tx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mrp_tx testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module mrp_tx_tb -o mrp_tx_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/mrp_tx_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -qx "STATUS: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
